// File: all.f
logic/bus_cmd_pkg.sv
logic/reg_map_pkg.sv
logic/cen_phase_gen.sv
logic/cycle_fsm.sv
logic/local_ram.sv
logic/apb_regs.sv
logic/sys_bus_top.sv
test/bus_checker.sv
test/tb_top.sv

// File: logic/apb_regs.sv
/* APB slave register block: address, write data, command, status, read data
   issues commands to the sequencer and latches results on done */
module apb_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [reg_map_pkg::apb_aw-1:0]      paddr,
    input  logic [31:0]                         pwdata,
    input  logic                                busy,
    input  logic                                done,
    input  logic                                err,
    input  logic [bus_cmd_pkg::data_w-1:0]      rd_data,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                cmd_start,
    output bus_cmd_pkg::bus_op_e                cmd_op,
    output logic [bus_cmd_pkg::addr_w-1:0]      cmd_addr,
    output logic [bus_cmd_pkg::data_w-1:0]      cmd_wdata,
    output logic                                irq_done
);

    bus_cmd_pkg::bus_op_e               wr_op;
    logic                               acc_wr;   // access phase of a write
    logic                               cmd_wr;
    logic                               cmd_bad;
    logic                               done_r;
    logic                               err_r;
    logic [bus_cmd_pkg::data_w-1:0]     rdata_r;
    logic [31:0]                        status;

    assign acc_wr  = psel & penable & pwrite;
    assign wr_op   = bus_cmd_pkg::bus_op_e'(pwdata[1:0]);
    assign cmd_wr  = acc_wr && (paddr == reg_map_pkg::REG_CMD);
    // busy covers the clk between start pulse and sequencer busy
    assign cmd_bad = busy | cmd_start | (wr_op == bus_cmd_pkg::OP_NONE);

    assign pready   = 1'b1;             // every access takes one cycle
    assign pslverr  = cmd_wr & cmd_bad;
    assign irq_done = done_r;

    always_comb begin
        status = '0;
        status[reg_map_pkg::ST_BUSY] = busy | cmd_start;
        status[reg_map_pkg::ST_DONE] = done_r;
        status[reg_map_pkg::ST_ERR]  = err_r;
    end

    // read mux, live during stalls
    always_comb begin
        prdata = '0;
        case (paddr)
            reg_map_pkg::REG_ADDR:   prdata[bus_cmd_pkg::addr_w-1:0] = cmd_addr;
            reg_map_pkg::REG_WDATA:  prdata[bus_cmd_pkg::data_w-1:0] = cmd_wdata;
            reg_map_pkg::REG_CMD:    prdata[1:0] = cmd_op;
            reg_map_pkg::REG_STATUS: prdata = status;
            reg_map_pkg::REG_RDATA:  prdata[bus_cmd_pkg::data_w-1:0] = rdata_r;
            default:                 prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_start <= 1'b0;
            cmd_op    <= bus_cmd_pkg::OP_NONE;
            cmd_addr  <= '0;
            cmd_wdata <= '0;
            done_r    <= 1'b0;
            err_r     <= 1'b0;
            rdata_r   <= '0;
        end else begin
            cmd_start <= 1'b0;
            if (acc_wr && paddr == reg_map_pkg::REG_ADDR) begin
                cmd_addr <= pwdata[bus_cmd_pkg::addr_w-1:0];
            end
            if (acc_wr && paddr == reg_map_pkg::REG_WDATA) begin
                cmd_wdata <= pwdata[bus_cmd_pkg::data_w-1:0];
            end
            if (cmd_wr && !cmd_bad) begin
                cmd_start <= 1'b1;
                cmd_op    <= wr_op;
                done_r    <= 1'b0;  // new command clears sticky done
            end
            if (done) begin
                done_r  <= 1'b1;
                err_r   <= err;
                rdata_r <= rd_data;
            end
        end
    end

endmodule

// File: logic/bus_cmd_pkg.sv
/* bus command opcodes, sequencer states and bus widths
   shared by the APB register block and the cycle sequencer */
package bus_cmd_pkg;

    localparam int addr_w = 16;   // 6809-style address bus
    localparam int data_w = 8;    // byte-wide data bus

    // host command, written to the low bits of REG_CMD
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,  // rejected by the slave
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2,
        OP_INC   = 2'd3   // read, add one, write back
    } bus_op_e;

    // bus cycle sequencer
    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,   // waiting for E
        S_DATA,   // waiting for Q
        S_WBACK,  // OP_INC second cycle, waits for next E
        S_DONE    // one cycle, done pulse
    } cyc_state_e;

endpackage

// File: logic/cen_phase_gen.sv
/* quarter-rate E/Q enable generator with wait gate
   freezes the phase while ROM data or the shared bus is not ready */
module cen_phase_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,       // base enable, E and Q run at 1/4 of it
    input  logic ram_cs,
    input  logic rom_cs,
    input  logic rom_ok,
    input  logic bus_busy,  // shared RAM owned by someone else
    output logic e_en,
    output logic q_en,
    output logic cpu_cen,
    output logic waitn
);

    logic [1:0] phase;      // 0 -> E, 2 -> Q
    logic       e_pend;
    logic       q_pend;

    // stall while ROM has not answered or the shared RAM is taken
    assign waitn = ~((rom_cs & ~rom_ok) | (ram_cs & bus_busy));

    // pending pulses are held across a stall and released once the gate opens
    assign e_en    = e_pend & waitn;
    assign q_en    = q_pend & waitn;
    assign cpu_cen = q_en;  // core enable follows Q

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= 2'd0;
            e_pend <= 1'b0;
            q_pend <= 1'b0;
        end else if (waitn) begin
            // one clk after the cen that saw the phase
            e_pend <= cen && (phase == 2'd0);
            q_pend <= cen && (phase == 2'd2);
            if (cen) begin
                phase <= phase + 2'd1;
            end
        end
        // gate closed: counter and pending enables frozen
    end

    // E and Q come from different phases, a stall must not merge them
    a_eq_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(e_en && q_en)
    ) else $error("e_en and q_en high together");

endmodule

// File: logic/cycle_fsm.sv
/* bus cycle sequencer for single read/write cycles and read-modify-write increment
   address on E, data on Q, RAM/ROM window decode and ROM write rejection */
module cycle_fsm #(
    parameter int RAM_AW = 10
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            e_en,
    input  logic                            q_en,
    input  logic                            cmd_start,
    input  bus_cmd_pkg::bus_op_e            cmd_op,
    input  logic [bus_cmd_pkg::addr_w-1:0]  cmd_addr,
    input  logic [bus_cmd_pkg::data_w-1:0]  cmd_wdata,
    input  logic [bus_cmd_pkg::data_w-1:0]  ram_q,
    input  logic [bus_cmd_pkg::data_w-1:0]  rom_data,
    output logic [bus_cmd_pkg::addr_w-1:0]  addr,
    output logic                            rnw,
    output logic                            ram_cs,
    output logic                            rom_cs,
    output logic                            ram_we,
    output logic                            busy,
    output logic                            done,
    output logic                            err,
    output logic [bus_cmd_pkg::data_w-1:0]  wr_data,
    output logic [bus_cmd_pkg::data_w-1:0]  rd_data
);

    bus_cmd_pkg::cyc_state_e                state;
    bus_cmd_pkg::bus_op_e                   op_r;
    logic [bus_cmd_pkg::addr_w-1:0]         req_addr;  // latched at start
    logic                                   req_ram;   // window decode of req_addr
    logic                                   start_ram;
    logic                                   rd_pend;   // RAM output valid this cycle
    logic [bus_cmd_pkg::data_w-1:0]         rd_r;

    assign start_ram = reg_map_pkg::in_ram_window(cmd_addr, RAM_AW);

    assign busy    = state != bus_cmd_pkg::S_IDLE;
    assign done    = state == bus_cmd_pkg::S_DONE;   // one clk after the last Q
    assign ram_we  = ram_cs & ~rnw;
    assign rd_data = rd_pend ? ram_q : rd_r;         // RAM read lands one clk after Q

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= bus_cmd_pkg::S_IDLE;
            op_r    <= bus_cmd_pkg::OP_NONE;
            addr    <= '0;
            rnw     <= 1'b1;
            ram_cs  <= 1'b0;
            rom_cs  <= 1'b0;
            err     <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= 1'b0;
            case (state)
                bus_cmd_pkg::S_IDLE: if (cmd_start) begin
                    op_r <= cmd_op;
                    err  <= 1'b0;
                    // no bus cycle for ROM writes or an empty opcode
                    if (cmd_op == bus_cmd_pkg::OP_NONE ||
                        (!start_ram && cmd_op != bus_cmd_pkg::OP_READ)) begin
                        err   <= 1'b1;
                        state <= bus_cmd_pkg::S_DONE;
                    end else begin
                        state <= bus_cmd_pkg::S_ADDR;
                    end
                end
                bus_cmd_pkg::S_ADDR: if (e_en) begin
                    addr   <= req_addr;     // held until Q
                    rnw    <= op_r != bus_cmd_pkg::OP_WRITE;
                    ram_cs <= req_ram;
                    rom_cs <= ~req_ram;
                    state  <= bus_cmd_pkg::S_DATA;
                end
                bus_cmd_pkg::S_DATA: if (q_en) begin
                    ram_cs  <= 1'b0;
                    rom_cs  <= 1'b0;
                    rnw     <= 1'b1;
                    rd_pend <= ram_cs & rnw;
                    if (op_r == bus_cmd_pkg::OP_INC && rnw) begin
                        state <= bus_cmd_pkg::S_WBACK;
                    end else begin
                        state <= bus_cmd_pkg::S_DONE;
                    end
                end
                bus_cmd_pkg::S_WBACK: if (e_en) begin
                    rnw    <= 1'b0;         // same address with the incremented byte
                    ram_cs <= 1'b1;
                    state  <= bus_cmd_pkg::S_DATA;
                end
                default: state <= bus_cmd_pkg::S_IDLE;  // S_DONE lasts one clk
            endcase
        end
    end

    // request and data bytes
    always_ff @(posedge clk) begin
        if (state == bus_cmd_pkg::S_IDLE && cmd_start) begin
            req_addr <= cmd_addr;
            req_ram  <= start_ram;
            wr_data  <= cmd_wdata;
        end
        if (state == bus_cmd_pkg::S_DATA && q_en && rom_cs) begin
            rd_r <= rom_data;   // ROM holds data while cs is up
        end
        if (rd_pend) begin
            rd_r    <= ram_q;
            wr_data <= ram_q + 8'd1;  // write-back byte ready well before the next E
        end
    end

    a_rom_read_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        rom_cs |-> rnw
    ) else $error("rom_cs with a write cycle");

    // address, direction and chip selects hold from E until Q through any stall
    a_bus_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ram_cs || rom_cs) && !q_en |=> $stable(addr) && $stable(rnw) &&
                                        $stable(ram_cs) && $stable(rom_cs)
    ) else $error("bus outputs moved before Q");

endmodule

// File: logic/local_ram.sv
/* local synchronous single-port RAM, clocked by the Q enable */
module local_ram #(
    parameter int RAM_AW = 10
) (
    input  logic                            clk,
    input  logic                            q_en,  // only Q moves the RAM
    input  logic                            we,
    input  logic [RAM_AW-1:0]               addr,
    input  logic [bus_cmd_pkg::data_w-1:0]  data,
    output logic [bus_cmd_pkg::data_w-1:0]  q
);

    logic [bus_cmd_pkg::data_w-1:0] mem [0:(1<<RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (q_en) begin
            if (we) begin
                mem[addr] <= data;
            end
            q <= mem[addr];  // read-first, old byte on a write
        end
    end

endmodule

// File: logic/reg_map_pkg.sv
/* APB register offsets, status bit positions and the RAM/ROM window split */
package reg_map_pkg;

    localparam int apb_aw = 5;    // byte offsets up to 0x10

    // one 32-bit word per register
    localparam logic [apb_aw-1:0] REG_ADDR   = 5'h00;
    localparam logic [apb_aw-1:0] REG_WDATA  = 5'h04;
    localparam logic [apb_aw-1:0] REG_CMD    = 5'h08;
    localparam logic [apb_aw-1:0] REG_STATUS = 5'h0C;
    localparam logic [apb_aw-1:0] REG_RDATA  = 5'h10;

    // REG_STATUS bits
    localparam int ST_BUSY = 0;   // command in flight
    localparam int ST_DONE = 1;   // sticky until next command
    localparam int ST_ERR  = 2;   // last command hit the ROM with a write

    // low window goes to local RAM, the rest to ROM (read only)
    function automatic logic in_ram_window(
        input logic [bus_cmd_pkg::addr_w-1:0] a,
        input int                             aw
    );
        logic [bus_cmd_pkg::addr_w-1:0] hi;
        hi = a >> aw;             // anything above the RAM bits
        return hi == '0;
    endfunction

endpackage

// File: logic/sys_bus_top.sv
/* bus-cycle subsystem top: APB registers, E/Q phase generator,
   cycle sequencer and local RAM */
module sys_bus_top #(
    parameter int RAM_AW = 10
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [reg_map_pkg::apb_aw-1:0]  paddr,
    input  logic [31:0]                     pwdata,
    input  logic                            bus_busy,
    input  logic                            rom_ok,
    input  logic [bus_cmd_pkg::data_w-1:0]  rom_data,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic [bus_cmd_pkg::addr_w-1:0]  rom_addr,  // shared bus address
    output logic                            rom_cs,
    output logic                            cpu_cen,
    output logic                            waitn,
    output logic                            irq_done
);

    logic                               cmd_start;
    bus_cmd_pkg::bus_op_e               cmd_op;
    logic [bus_cmd_pkg::addr_w-1:0]     cmd_addr;
    logic [bus_cmd_pkg::data_w-1:0]     cmd_wdata;
    logic                               busy, done, err;
    logic [bus_cmd_pkg::data_w-1:0]     rd_data;
    logic                               e_en, q_en;
    logic                               ram_cs, ram_we;
    logic [bus_cmd_pkg::data_w-1:0]     wr_data;
    logic [bus_cmd_pkg::data_w-1:0]     ram_q;

    apb_regs u_regs (
        .clk       ( clk       ), .rst_n    ( rst_n     ),
        .psel      ( psel      ), .penable  ( penable   ),
        .pwrite    ( pwrite    ), .paddr    ( paddr     ),
        .pwdata    ( pwdata    ), .busy     ( busy      ),
        .done      ( done      ), .err      ( err       ),
        .rd_data   ( rd_data   ), .prdata   ( prdata    ),
        .pready    ( pready    ), .pslverr  ( pslverr   ),
        .cmd_start ( cmd_start ), .cmd_op   ( cmd_op    ),
        .cmd_addr  ( cmd_addr  ), .cmd_wdata( cmd_wdata ),
        .irq_done  ( irq_done  )
    );

    cen_phase_gen u_phase (
        .clk     ( clk      ), .rst_n   ( rst_n    ),
        .cen     ( cen      ), .ram_cs  ( ram_cs   ),
        .rom_cs  ( rom_cs   ), .rom_ok  ( rom_ok   ),
        .bus_busy( bus_busy ), .e_en    ( e_en     ),
        .q_en    ( q_en     ), .cpu_cen ( cpu_cen  ),
        .waitn   ( waitn    )
    );

    cycle_fsm #(.RAM_AW(RAM_AW)) u_fsm (
        .clk      ( clk       ), .rst_n    ( rst_n    ),
        .e_en     ( e_en      ), .q_en     ( q_en     ),
        .cmd_start( cmd_start ), .cmd_op   ( cmd_op   ),
        .cmd_addr ( cmd_addr  ), .cmd_wdata( cmd_wdata),
        .ram_q    ( ram_q     ), .rom_data ( rom_data ),
        .addr     ( rom_addr  ), .rnw      (          ),  // direction reaches RAM as ram_we
        .ram_cs   ( ram_cs    ), .rom_cs   ( rom_cs   ),
        .ram_we   ( ram_we    ), .busy     ( busy     ),
        .done     ( done      ), .err      ( err      ),
        .wr_data  ( wr_data   ), .rd_data  ( rd_data  )
    );

    local_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk  ( clk                    ),
        .q_en ( q_en                   ),
        .we   ( ram_we                 ),
        .addr ( rom_addr[RAM_AW-1:0]   ),  // low window bits only
        .data ( wr_data                ),
        .q    ( ram_q                  )
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the bus subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_top -Mdir build -o sim_tb -f all.f
./build/sim_tb | tee sim.log
if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/bus_checker.sv
/* APB monitor that checks RDATA and the status err bit against the tests file,
   pslverr, pready, irq_done, the ROM address and cpu_cen, and records RAM stalls */
module bus_checker #(
    parameter int RAM_AW   = 10,
    parameter int MAX_TEST = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    input  logic [15:0] rom_addr,
    input  logic        rom_cs,
    input  logic        cpu_cen,
    input  logic        waitn,
    input  logic        irq_done,
    output int          err_count,
    output int          checks,
    output logic        stall_seen
);

    logic [15:0] tests [0:4*MAX_TEST-1];
    int          idx;            // current test line
    int          cmd_writes;     // REG_CMD writes within this test
    logic        cen_prev;       // cpu_cen one clk earlier

    initial begin
        for (int i = 0; i < 4*MAX_TEST; i++) begin
            tests[i] = 16'hFFFF;
        end
        $readmemh("test/bus_tests.txt", tests);
    end

    // write-type opcode at or above 2**RAM_AW must come back with err
    function automatic logic rom_write(input logic [15:0] op, input logic [15:0] a);
        return (bus_cmd_pkg::bus_op_e'(op[1:0]) != bus_cmd_pkg::OP_READ) &&
               (int'(a) >= (1 << RAM_AW));
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks = checks + 1;
        if (got !== exp) begin
            err_count = err_count + 1;
            $display("ERR t=%0t %s expected %h got %h (test %0d)", $time, name, exp, got, idx);
        end
    endtask

    // APB and bus outputs have settled by the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            err_count  = 0;
            checks     = 0;
            stall_seen = 1'b0;
            idx        = 0;
            cmd_writes = 0;
            cen_prev   = 1'b0;
        end else begin
            if (!waitn && !rom_cs) begin
                stall_seen = 1'b1;   // gate closed by bus_busy on a RAM cycle
            end
            if (cpu_cen && (!waitn || cen_prev)) begin
                err_count = err_count + 1;
                $display("cpu_cen high during a stall or for two clks in a row at t=%0t",
                         $time);
            end
            cen_prev = cpu_cen;
            if (rom_cs && idx < MAX_TEST) begin
                compare("rom_addr", {16'h0, tests[4*idx+1]}, {16'h0, rom_addr});
            end
            if (psel && penable && idx < MAX_TEST) begin
                compare("pready", 32'h1, {31'h0, pready});
                if (pwrite && paddr == reg_map_pkg::REG_CMD) begin
                    cmd_writes = cmd_writes + 1;
                    if (cmd_writes == 1) begin
                        // done of the previous command is still sticky
                        compare("irq_done", {31'h0, idx > 0}, {31'h0, irq_done});
                    end
                    compare("pslverr", {31'h0, cmd_writes > 1}, {31'h0, pslverr});
                end
                if (!pwrite && paddr == reg_map_pkg::REG_STATUS &&
                    prdata[reg_map_pkg::ST_DONE]) begin
                    compare("status_err", {31'h0, rom_write(tests[4*idx], tests[4*idx+1])},
                            {31'h0, prdata[reg_map_pkg::ST_ERR]});
                end
                if (!pwrite && paddr == reg_map_pkg::REG_RDATA) begin
                    compare("irq_done", 32'h1, {31'h0, irq_done});
                    if (tests[4*idx+3] <= 16'h00FF) begin   // 100 = no check
                        compare("rdata", {16'h0, tests[4*idx+3]}, prdata);
                    end
                    idx        = idx + 1;
                    cmd_writes = 0;
                end
            end
        end
    end

endmodule

// File: test/bus_tests.txt
// columns, all hex: opcode address wdata expected (opcode 1 read, 2 write, 3 inc)
// opcode +4 adds a second REG_CMD write while busy, expected 100 means not checked
2 0010 A5 100
1 0010 00 A5
2 03FF 3C 100
1 03FF 00 3C
2 0000 FF 100
3 0000 00 FF
1 0000 00 00
3 03FF 00 3C
1 03FF 00 3D
1 1234 00 7C
1 F00F 00 A5
1 8001 00 DB
1 0400 00 5E
2 0400 11 100
1 0000 00 00
3 0410 00 100
1 0010 00 A5
5 0010 00 A5
5 2345 00 3C
7 0010 00 A5
1 0010 00 A6
2 0155 5A 100
3 0155 00 5A
1 0155 00 5B
2 0200 80 100
1 0200 00 80

// File: test/tb_top.sv
/* testbench top with clock, reset, cen pattern, ROM and shared-bus models,
   APB command driver fed from the tests file and a watchdog */
module tb_top;

    localparam int          RAM_AW   = 10;
    localparam int          CLK_T    = 100;
    localparam int          MAX_TEST = 64;
    localparam logic [31:0] SEED     = 32'h89deda2d;

    logic        clk      = 1'b0;
    logic        rst_n    = 1'b0;
    logic        cen      = 1'b0;
    logic        psel     = 1'b0;
    logic        penable  = 1'b0;
    logic        pwrite   = 1'b0;
    logic [4:0]  paddr    = 5'h0;
    logic [31:0] pwdata   = 32'h0;
    logic        bus_busy = 1'b0;
    logic        rom_ok   = 1'b1;
    logic [7:0]  rom_data = 8'h0;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [15:0] rom_addr;
    logic        rom_cs;
    logic        cpu_cen;
    logic        waitn;
    logic        irq_done;

    logic [15:0] tests [0:4*MAX_TEST-1];   // op, addr, wdata, expected per test
    int          n_tests   = 0;
    logic [1:0]  cen_cnt   = 2'd0;
    logic [1:0]  rom_left  = 2'd0;         // clks until rom_ok
    logic [2:0]  busy_left = 3'd0;         // clks left in a busy burst
    logic [31:0] rom_draw;
    logic [31:0] busy_draw;
    logic [31:0] seed_ret;
    int          err_count;
    int          checks;
    logic        stall_seen;

    sys_bus_top #(.RAM_AW(RAM_AW)) dut (
        .clk     ( clk      ), .rst_n   ( rst_n    ), .cen      ( cen      ),
        .psel    ( psel     ), .penable ( penable  ), .pwrite   ( pwrite   ),
        .paddr   ( paddr    ), .pwdata  ( pwdata   ), .bus_busy ( bus_busy ),
        .rom_ok  ( rom_ok   ), .rom_data( rom_data ), .prdata   ( prdata   ),
        .pready  ( pready   ), .pslverr ( pslverr  ), .rom_addr ( rom_addr ),
        .rom_cs  ( rom_cs   ), .cpu_cen ( cpu_cen  ), .waitn    ( waitn    ),
        .irq_done( irq_done )
    );

    bus_checker #(.RAM_AW(RAM_AW), .MAX_TEST(MAX_TEST)) chk (
        .clk      ( clk      ), .rst_n    ( rst_n    ), .psel      ( psel      ),
        .penable  ( penable  ), .pwrite   ( pwrite   ), .paddr     ( paddr     ),
        .prdata   ( prdata   ), .pready   ( pready   ), .pslverr   ( pslverr   ),
        .rom_addr ( rom_addr ), .rom_cs   ( rom_cs   ), .cpu_cen   ( cpu_cen   ),
        .waitn    ( waitn    ), .irq_done ( irq_done ), .err_count ( err_count ),
        .checks   ( checks   ), .stall_seen( stall_seen )
    );

    always #(CLK_T/2) clk = ~clk;

    // cen high two clks out of three
    always @(posedge clk) begin
        cen_cnt <= (cen_cnt == 2'd2) ? 2'd0 : cen_cnt + 2'd1;
        cen     <= (cen_cnt != 2'd1);
    end

    // ROM model with data from the address and rom_ok after 0 to 3 clks
    always @(posedge clk) begin
        rom_data <= rom_addr[15:8] ^ rom_addr[7:0] ^ 8'h5A;
        if (!rom_cs) begin
            rom_draw = $urandom % 4;       // redrawn until cs rises
            rom_left <= rom_draw[1:0];
            rom_ok   <= (rom_draw == 32'd0);
        end else if (rom_left != 2'd0) begin
            rom_left <= rom_left - 2'd1;
            rom_ok   <= (rom_left == 2'd1);
        end
    end

    // shared bus owner grabbing the bus in bursts of 1 to 4 clks
    always @(posedge clk) begin
        busy_draw = $urandom;
        if (busy_left != 3'd0) begin
            busy_left <= busy_left - 3'd1;
        end else if (busy_draw[2:0] == 3'd0) begin
            busy_left <= 3'd1 + {1'b0, busy_draw[5:4]};
        end
        bus_busy <= (busy_left != 3'd0);
    end

    task automatic apb_write(input logic [4:0] a, input logic [31:0] d);
        @(posedge clk);
        psel    <= 1'b1;                   // setup
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= a;
        pwdata  <= d;
        @(posedge clk);
        penable <= 1'b1;                   // access cycle
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] a, output logic [31:0] d);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= a;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        d = prdata;                        // settled mid access cycle
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // one command with address, data, opcode, done poll and result fetch
    task automatic run_test(input int t);
        logic [15:0] op;
        logic [31:0] st;
        logic [31:0] rd;
        op = tests[4*t];
        apb_write(reg_map_pkg::REG_ADDR, {16'h0, tests[4*t+1]});
        apb_write(reg_map_pkg::REG_WDATA, {16'h0, tests[4*t+2]});
        apb_write(reg_map_pkg::REG_CMD, {30'h0, op[1:0]});
        if (op[2]) begin
            apb_write(reg_map_pkg::REG_CMD, 32'h1);  // lands while busy
        end
        st = 32'h0;
        while (!st[reg_map_pkg::ST_DONE]) begin
            apb_read(reg_map_pkg::REG_STATUS, st);
        end
        apb_read(reg_map_pkg::REG_RDATA, rd);
    endtask

    task automatic finish_run;
        int total;
        total = err_count;
        if (!stall_seen) begin
            $display("no RAM wait stall was seen, waitn never went low during a RAM cycle");
            total = total + 1;
        end
        $display("errors: %0d, checks: %0d", total, checks);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        seed_ret = $urandom(SEED);
        for (int i = 0; i < 4*MAX_TEST; i++) begin
            tests[i] = 16'hFFFF;           // end marker
        end
        $readmemh("test/bus_tests.txt", tests);
        while (n_tests < MAX_TEST && tests[4*n_tests] != 16'hFFFF) begin
            n_tests = n_tests + 1;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        repeat (4) @(posedge clk);
        finish_run();
    end

    // watchdog allows 400 clks per test line, counted once reset is released
    initial begin
        wait (rst_n === 1'b1);
        #(n_tests * 400 * CLK_T);
        $display("timeout: %0d tests did not finish in %0d clks", n_tests, n_tests * 400);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
